// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= hc_tb
FILELIST  ?= files.f
VFLAGS    ?= --binary --timing --assert -j 0
OBJ_DIR   ?= obj_dir
PASS_MSG  := sim passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== design/hc_copy_engine.sv ====
// ====================================================================
// Copy engine reading source lines and writing each one to the
// destination buffer, with completion tracked by write acks
// ====================================================================
`timescale 1ns/1ps
`include "host_chan_defines.svh"

module hc_copy_engine
(
    input  logic                        clk,
    input  logic                        arst_n,
    input  host_chan_pkg::copy_cfg_t    cfg,
    input  logic                        start,
    output host_chan_pkg::copy_status_t status,
    output logic                        done_pulse,
    output host_chan_pkg::c0_tx_ext_t   c0_tx,
    output host_chan_pkg::c1_tx_ext_t   c1_tx,
    input  host_chan_pkg::c0_rx_t       c0_rx,
    input  host_chan_pkg::c1_rx_t       c1_rx,
    input  logic                        c0_alm_full,
    input  logic                        c1_alm_full
);

    localparam int ADDR_W = `HC_ADDR_W;

    // Job captured at start, stable for the whole copy
    host_chan_pkg::copy_cfg_t job;

    logic        busy;
    logic        done;
    logic [15:0] reads_issued;
    logic [15:0] writes_acked;
    logic        issue_ok;

    always_ff @(posedge clk)
    begin
        if (start)
        begin
            job <= cfg;
        end
    end

    // A read goes out only while lines remain and the host has room
    // Almost-full here is already delayed by the shim receive stages
    assign issue_ok = busy && (reads_issued != job.len) && !c0_alm_full && !c1_alm_full;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            busy         <= 1'b0;
            done         <= 1'b0;
            done_pulse   <= 1'b0;
            reads_issued <= '0;
            writes_acked <= '0;
            c0_tx        <= '0;
        end
        else
        begin
            done_pulse       <= 1'b0;
            c0_tx.base.valid <= 1'b0;
            if (start)
            begin
                // Empty job finishes right away without touching the host
                busy         <= (cfg.len != '0);
                done         <= (cfg.len == '0);
                done_pulse   <= (cfg.len == '0);
                reads_issued <= '0;
                writes_acked <= '0;
            end
            else if (busy)
            begin
                if (issue_ok)
                begin
                    // The line index doubles as the tag so the response
                    // knows where to land in the destination
                    c0_tx.base.valid <= 1'b1;
                    c0_tx.base.addr  <= job.src_base + ADDR_W'(reads_issued);
                    c0_tx.base.mdata <= reads_issued;
                    reads_issued     <= reads_issued + 16'd1;
                end
                if (c1_rx.valid)
                begin
                    writes_acked <= writes_acked + 16'd1;
                    // Last ack ends the job
                    if (writes_acked + 16'd1 == job.len)
                    begin
                        busy       <= 1'b0;
                        done       <= 1'b1;
                        done_pulse <= 1'b1;
                    end
                end
            end
        end
    end

    // Read data goes straight back out as a write with no buffering,
    // relying on the host accepting requests past almost-full
    always_comb
    begin
        c1_tx                 = '0;
        c1_tx.base.valid      = c0_rx.valid;
        c1_tx.base.addr       = job.dst_base + ADDR_W'(c0_rx.mdata);
        c1_tx.base.data       = c0_rx.data;
        c1_tx.base.mdata      = c0_rx.mdata;
        // Addresses are physical and lines are independent
        c1_tx.addr_is_virtual = 1'b0;
        c1_tx.order_hint      = 1'b0;
    end

    always_comb
    begin
        status.busy         = busy;
        status.done         = done;
        status.reads_issued = reads_issued;
        status.writes_acked = writes_acked;
    end

    // Responses only come back for reads of the current job
    a_no_rsp_idle: assert property (@(posedge clk) disable iff (!arst_n)
        !busy |-> !c0_rx.valid)
        else $error("read response while idle");

    // The register block must not restart a running copy
    a_no_start_busy: assert property (@(posedge clk) disable iff (!arst_n)
        start |-> !busy)
        else $error("start while busy");

endmodule

// ==== design/hc_csr.sv ====
// ====================================================================
// Configuration and status registers for the copy engine
// ====================================================================
`timescale 1ns/1ps
`include "host_chan_defines.svh"

module hc_csr
(
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        cfg_wr,
    input  logic                        cfg_rd,
    input  logic [2:0]                  cfg_addr,
    input  logic [63:0]                 cfg_wdata,
    output logic [63:0]                 cfg_rdata,
    output logic                        cfg_rvalid,
    output host_chan_pkg::copy_cfg_t    cfg,
    output logic                        start,
    input  host_chan_pkg::copy_status_t status
);

    localparam int ADDR_W = `HC_ADDR_W;

    // Register indices
    localparam logic [2:0] REG_SRC    = 3'd0;
    localparam logic [2:0] REG_DST    = 3'd1;
    localparam logic [2:0] REG_LEN    = 3'd2;
    localparam logic [2:0] REG_CTRL   = 3'd3;
    localparam logic [2:0] REG_STATUS = 3'd4;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            cfg        <= '0;
            start      <= 1'b0;
            cfg_rvalid <= 1'b0;
        end
        else
        begin
            // Start is a single-cycle strobe
            start      <= 1'b0;
            cfg_rvalid <= cfg_rd;
            if (cfg_wr)
            begin
                case (cfg_addr)
                    REG_SRC:  cfg.src_base <= cfg_wdata[ADDR_W-1:0];
                    REG_DST:  cfg.dst_base <= cfg_wdata[ADDR_W-1:0];
                    REG_LEN:  cfg.len      <= cfg_wdata[15:0];
                    REG_CTRL: start        <= cfg_wdata[0];
                    default:  ;
                endcase
            end
        end
    end

    // Read data lines up with cfg_rvalid one cycle after the strobe
    always_ff @(posedge clk)
    begin
        if (cfg_rd)
        begin
            case (cfg_addr)
                REG_SRC:    cfg_rdata <= 64'(cfg.src_base);
                REG_DST:    cfg_rdata <= 64'(cfg.dst_base);
                REG_LEN:    cfg_rdata <= 64'(cfg.len);
                REG_STATUS: cfg_rdata <= {status.writes_acked, 16'h0,
                                          status.reads_issued, 14'h0,
                                          status.done, status.busy};
                // Control is write-only, unmapped indices read zero
                default:    cfg_rdata <= '0;
            endcase
        end
    end

endmodule

// ==== design/hc_pipe_stages.sv ====
// ====================================================================
// Register chain for any packed payload, cleared to zero on reset
// ====================================================================
`timescale 1ns/1ps

module hc_pipe_stages
#(
    parameter type T        = logic,
    parameter int  N_STAGES = 1
)
(
    input  logic clk,
    input  logic arst_n,
    input  T     in,
    output T     out
);

    // Stage 0 takes the input, the last stage drives the output
    T stage [N_STAGES];

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            // Whole payload is cleared so every embedded valid reads idle
            for (int i = 0; i < N_STAGES; i++)
            begin
                stage[i] <= '0;
            end
        end
        else
        begin
            stage[0] <= in;
            for (int i = 1; i < N_STAGES; i++)
            begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign out = stage[N_STAGES-1];

    // A zero-depth chain has no register to hold the payload
    a_depth: assert property (@(posedge clk) N_STAGES >= 1)
        else $error("pipe depth must be at least one stage");

endmodule

// ==== design/hc_shim.sv ====
// ====================================================================
// Host channel shim that strips request hints to the base format
// and adds optional register stages on both directions for timing
// ====================================================================
`timescale 1ns/1ps
`include "host_chan_defines.svh"

module hc_shim
#(
    parameter int REGISTER_INPUTS  = 1,
    parameter int REGISTER_OUTPUTS = 1,
    parameter int N_REG_STAGES     = `HC_N_REG_STAGES
)
(
    input  logic                    clk,
    input  logic                    arst_n,
    input  host_chan_pkg::c0_tx_ext_t c0_tx,
    input  host_chan_pkg::c1_tx_ext_t c1_tx,
    output host_chan_pkg::c0_rx_t   c0_rx,
    output host_chan_pkg::c1_rx_t   c1_rx,
    output logic                    c0_alm_full,
    output logic                    c1_alm_full,
    output host_chan_pkg::host_tx_t host_tx,
    input  host_chan_pkg::host_rx_t host_rx
);

    // Requests after the hint fields are dropped
    host_chan_pkg::host_tx_t tx_base;
    // Host responses as the engine sees them
    host_chan_pkg::host_rx_t rx_eng;

    // Virtual addressing and ordering are not enforced here
    // The hints only matter to a translation layer, which this host lacks
    assign tx_base.c0 = c0_tx.base;
    assign tx_base.c1 = c1_tx.base;

    generate
        if (REGISTER_OUTPUTS != 0)
        begin : g_reg_out
            hc_pipe_stages
            #(
                .T        (host_chan_pkg::host_tx_t),
                .N_STAGES (N_REG_STAGES)
            )
            i_tx_pipe
            (
                .clk    (clk),
                .arst_n (arst_n),
                .in     (tx_base),
                .out    (host_tx)
            );
        end
        else
        begin : g_wire_out
            assign host_tx = tx_base;
        end
    endgenerate

    // Almost-full travels with the responses, so the engine sees it late
    // and the host has to absorb the requests already in the pipe
    generate
        if (REGISTER_INPUTS != 0)
        begin : g_reg_in
            hc_pipe_stages
            #(
                .T        (host_chan_pkg::host_rx_t),
                .N_STAGES (N_REG_STAGES)
            )
            i_rx_pipe
            (
                .clk    (clk),
                .arst_n (arst_n),
                .in     (host_rx),
                .out    (rx_eng)
            );
        end
        else
        begin : g_wire_in
            assign rx_eng = host_rx;
        end
    endgenerate

    assign c0_rx       = rx_eng.c0;
    assign c1_rx       = rx_eng.c1;
    assign c0_alm_full = rx_eng.c0_alm_full;
    assign c1_alm_full = rx_eng.c1_alm_full;

    // Holds even with pass-through outputs, where it relies on the engine
    a_tx_quiet_in_reset: assert property (@(posedge clk)
        !arst_n |-> !(host_tx.c0.valid || host_tx.c1.valid))
        else $error("transmit valid high during reset");

    a_rx_valid_known: assert property (@(posedge clk) disable iff (!arst_n)
        !$isunknown({host_rx.c0.valid, host_rx.c1.valid}))
        else $error("receive valid is unknown");

endmodule

// ==== design/hc_top.sv ====
// ====================================================================
// Host channel subsystem with register block, copy engine and shim
// ====================================================================
`timescale 1ns/1ps
`include "host_chan_defines.svh"

module hc_top
(
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    cfg_wr,
    input  logic                    cfg_rd,
    input  logic [2:0]              cfg_addr,
    input  logic [63:0]             cfg_wdata,
    output logic [63:0]             cfg_rdata,
    output logic                    cfg_rvalid,
    output logic                    done_irq,
    output host_chan_pkg::host_tx_t host_tx,
    input  host_chan_pkg::host_rx_t host_rx
);

    host_chan_pkg::copy_cfg_t    cfg;
    logic                        start;
    host_chan_pkg::copy_status_t status;

    // Engine side of the shim
    host_chan_pkg::c0_tx_ext_t eng_c0_tx;
    host_chan_pkg::c1_tx_ext_t eng_c1_tx;
    host_chan_pkg::c0_rx_t     eng_c0_rx;
    host_chan_pkg::c1_rx_t     eng_c1_rx;
    logic                      eng_c0_alm_full;
    logic                      eng_c1_alm_full;

    hc_csr i_csr
    (
        .clk        (clk),
        .arst_n     (arst_n),
        .cfg_wr     (cfg_wr),
        .cfg_rd     (cfg_rd),
        .cfg_addr   (cfg_addr),
        .cfg_wdata  (cfg_wdata),
        .cfg_rdata  (cfg_rdata),
        .cfg_rvalid (cfg_rvalid),
        .cfg        (cfg),
        .start      (start),
        .status     (status)
    );

    hc_copy_engine i_copy_engine
    (
        .clk         (clk),
        .arst_n      (arst_n),
        .cfg         (cfg),
        .start       (start),
        .status      (status),
        .done_pulse  (done_irq),
        .c0_tx       (eng_c0_tx),
        .c1_tx       (eng_c1_tx),
        .c0_rx       (eng_c0_rx),
        .c1_rx       (eng_c1_rx),
        .c0_alm_full (eng_c0_alm_full),
        .c1_alm_full (eng_c1_alm_full)
    );

    // Both directions registered for timing toward the host
    hc_shim
    #(
        .REGISTER_INPUTS  (1),
        .REGISTER_OUTPUTS (1),
        .N_REG_STAGES     (`HC_N_REG_STAGES)
    )
    i_shim
    (
        .clk         (clk),
        .arst_n      (arst_n),
        .c0_tx       (eng_c0_tx),
        .c1_tx       (eng_c1_tx),
        .c0_rx       (eng_c0_rx),
        .c1_rx       (eng_c1_rx),
        .c0_alm_full (eng_c0_alm_full),
        .c1_alm_full (eng_c1_alm_full),
        .host_tx     (host_tx),
        .host_rx     (host_rx)
    );

endmodule

// ==== design/host_chan_defines.svh ====
// ====================================================================
// Host channel widths and shim pipeline depth shared by the design
// ====================================================================
`ifndef HOST_CHAN_DEFINES_SVH
`define HOST_CHAN_DEFINES_SVH

// Cache line address, counted in 64-byte lines rather than bytes
`define HC_ADDR_W 42

// One full cache line of payload per request
`define HC_DATA_W 512

// Request tag returned with every response
// The copy engine stores the line index here
`define HC_MDATA_W 16

// Register stages the shim inserts on each direction by default
`define HC_N_REG_STAGES 1

`endif

// ==== design/host_chan_pkg.sv ====
// ====================================================================
// Host channel request, response and copy job types
// ====================================================================
`include "host_chan_defines.svh"

package host_chan_pkg;

    // Base read request as seen by the host
    typedef struct packed {
        logic                   valid;
        logic [`HC_ADDR_W-1:0]  addr;
        logic [`HC_MDATA_W-1:0] mdata;
    } c0_tx_t;

    // Base write request as seen by the host
    typedef struct packed {
        logic                   valid;
        logic [`HC_ADDR_W-1:0]  addr;
        logic [`HC_DATA_W-1:0]  data;
        logic [`HC_MDATA_W-1:0] mdata;
    } c1_tx_t;

    // Extended requests carry hints that the shim drops on the way out
    typedef struct packed {
        c0_tx_t base;
        logic   addr_is_virtual;
        logic   order_hint;
    } c0_tx_ext_t;

    typedef struct packed {
        c1_tx_t base;
        logic   addr_is_virtual;
        logic   order_hint;
    } c1_tx_ext_t;

    // Read response with the line data
    typedef struct packed {
        logic                   valid;
        logic [`HC_MDATA_W-1:0] mdata;
        logic [`HC_DATA_W-1:0]  data;
    } c0_rx_t;

    // Write acknowledgement, tag only
    typedef struct packed {
        logic                   valid;
        logic [`HC_MDATA_W-1:0] mdata;
    } c1_rx_t;

    // Everything sent toward the host in one cycle
    typedef struct packed {
        c0_tx_t c0;
        c1_tx_t c1;
    } host_tx_t;

    // Everything returned by the host in one cycle, flow control included
    typedef struct packed {
        c0_rx_t c0;
        c1_rx_t c1;
        logic   c0_alm_full;
        logic   c1_alm_full;
    } host_rx_t;

    // One copy job as programmed through the register block
    typedef struct packed {
        logic [`HC_ADDR_W-1:0] src_base;
        logic [`HC_ADDR_W-1:0] dst_base;
        logic [15:0]           len;
    } copy_cfg_t;

    typedef struct packed {
        logic        busy;
        logic        done;
        logic [15:0] reads_issued;
        logic [15:0] writes_acked;
    } copy_status_t;

endpackage

// ==== dv/hc_host_model.sv ====
// ====================================================================
// Host memory model with random response latency and almost-full
// ====================================================================
`timescale 1ns/1ps
`include "host_chan_defines.svh"

module hc_host_model
(
    input  logic                    clk,
    input  logic                    arst_n,
    input  host_chan_pkg::host_tx_t host_tx,
    output host_chan_pkg::host_rx_t host_rx
);

    localparam int ADDR_W  = `HC_ADDR_W;
    localparam int DATA_W  = `HC_DATA_W;
    localparam int MAX_LAT = 20;

    int seed = 32'h43f1;
    int cycle;

    // Sparse line storage, a line gets its content on first touch
    logic [DATA_W-1:0] mem [logic [ADDR_W-1:0]];

    // Outstanding requests waiting for their response cycle
    int                     rd_due  [$];
    logic [ADDR_W-1:0]      rd_addr [$];
    logic [`HC_MDATA_W-1:0] rd_tag  [$];
    int                     wr_due  [$];
    logic [`HC_MDATA_W-1:0] wr_tag  [$];

    // Every request in arrival order with the cycle it was seen
    int                log_cycle [$];
    logic              log_write [$];
    logic [ADDR_W-1:0] log_addr  [$];

    // Each 32-bit word mixes the random stream with the full line address
    function automatic logic [DATA_W-1:0] fill_line(input logic [ADDR_W-1:0] addr);
        logic [DATA_W-1:0] line;
        for (int w = 0; w < DATA_W / 32; w++)
        begin
            line[w*32 +: 32] = $random(seed) ^ addr[31:0] ^ 32'(addr >> 32) ^ w;
        end
        return line;
    endfunction

    // Lets the testbench look at memory without touching the fill stream
    function automatic logic [DATA_W-1:0] line_at(input logic [ADDR_W-1:0] addr);
        if (mem.exists(addr))
        begin
            return mem[addr];
        end
        return '0;
    endfunction

    always @(posedge clk or negedge arst_n)
    begin
        int                idx;
        logic [ADDR_W-1:0] a;
        if (!arst_n)
        begin
            host_rx <= '0;
            cycle = 0;
            rd_due.delete();
            rd_addr.delete();
            rd_tag.delete();
            wr_due.delete();
            wr_tag.delete();
        end
        else
        begin
            cycle++;
            host_rx.c0.valid <= 1'b0;
            host_rx.c1.valid <= 1'b0;

            // Requests are always taken, almost-full is only advice
            if (host_tx.c0.valid)
            begin
                rd_due.push_back(cycle + 1 + int'({$random(seed)} % MAX_LAT));
                rd_addr.push_back(host_tx.c0.addr);
                rd_tag.push_back(host_tx.c0.mdata);
                log_cycle.push_back(cycle);
                log_write.push_back(1'b0);
                log_addr.push_back(host_tx.c0.addr);
            end
            if (host_tx.c1.valid)
            begin
                mem[host_tx.c1.addr] = host_tx.c1.data;
                wr_due.push_back(cycle + 1 + int'({$random(seed)} % MAX_LAT));
                wr_tag.push_back(host_tx.c1.mdata);
                log_cycle.push_back(cycle);
                log_write.push_back(1'b1);
                log_addr.push_back(host_tx.c1.addr);
            end

            // First queued read whose time has come, so order follows latency
            idx = -1;
            for (int i = 0; i < rd_due.size(); i++)
            begin
                if (idx < 0 && rd_due[i] <= cycle)
                begin
                    idx = i;
                end
            end
            if (idx >= 0)
            begin
                a = rd_addr[idx];
                if (!mem.exists(a))
                begin
                    mem[a] = fill_line(a);
                end
                host_rx.c0.valid <= 1'b1;
                host_rx.c0.mdata <= rd_tag[idx];
                host_rx.c0.data  <= mem[a];
                rd_due.delete(idx);
                rd_addr.delete(idx);
                rd_tag.delete(idx);
            end

            // Write acks go out the same way, one per cycle
            idx = -1;
            for (int i = 0; i < wr_due.size(); i++)
            begin
                if (idx < 0 && wr_due[i] <= cycle)
                begin
                    idx = i;
                end
            end
            if (idx >= 0)
            begin
                host_rx.c1.valid <= 1'b1;
                host_rx.c1.mdata <= wr_tag[idx];
                wr_due.delete(idx);
                wr_tag.delete(idx);
            end

            // Levels flip now and then, leaving stretches of several cycles
            if ({$random(seed)} % 8 == 0)
            begin
                host_rx.c0_alm_full <= !host_rx.c0_alm_full;
            end
            if ({$random(seed)} % 16 == 0)
            begin
                host_rx.c1_alm_full <= !host_rx.c1_alm_full;
            end
        end
    end

endmodule

// ==== dv/hc_tb.sv ====
// ====================================================================
// Testbench for the host channel subsystem with random copy jobs
// ====================================================================
`timescale 1ns/1ps
`include "host_chan_defines.svh"

module hc_tb;

    localparam int ADDR_W       = `HC_ADDR_W;
    localparam int DATA_W       = `HC_DATA_W;
    localparam int CLK_HALF     = 50;
    localparam int N_JOBS       = 6;
    localparam int MAX_LEN      = 40;
    localparam int DONE_TIMEOUT = 5000;
    localparam int SETTLE       = 30;
    localparam int MAX_AF_READS = 2 * `HC_N_REG_STAGES + 1;

    // Register map indices
    localparam logic [2:0] REG_SRC    = 3'd0;
    localparam logic [2:0] REG_DST    = 3'd1;
    localparam logic [2:0] REG_LEN    = 3'd2;
    localparam logic [2:0] REG_CTRL   = 3'd3;
    localparam logic [2:0] REG_STATUS = 3'd4;

    logic                    clk;
    logic                    arst_n;
    logic                    cfg_wr;
    logic                    cfg_rd;
    logic [2:0]              cfg_addr;
    logic [63:0]             cfg_wdata;
    logic [63:0]             cfg_rdata;
    logic                    cfg_rvalid;
    logic                    done_irq;
    host_chan_pkg::host_tx_t host_tx;
    host_chan_pkg::host_rx_t host_rx;

    int   seed = 32'h43f1;
    int   irq_seen;
    int   af_reads;
    logic af_prev;

    hc_top i_hc_top
    (
        .clk        (clk),
        .arst_n     (arst_n),
        .cfg_wr     (cfg_wr),
        .cfg_rd     (cfg_rd),
        .cfg_addr   (cfg_addr),
        .cfg_wdata  (cfg_wdata),
        .cfg_rdata  (cfg_rdata),
        .cfg_rvalid (cfg_rvalid),
        .done_irq   (done_irq),
        .host_tx    (host_tx),
        .host_rx    (host_rx)
    );

    hc_host_model i_host_model
    (
        .clk     (clk),
        .arst_n  (arst_n),
        .host_tx (host_tx),
        .host_rx (host_rx)
    );

    always #CLK_HALF clk = ~clk;

    task automatic check_value(input string name, input logic [DATA_W-1:0] got,
                               input logic [DATA_W-1:0] exp);
        if (got !== exp)
        begin
            $display("[FAIL] %0t %s got %0h expected %0h", $time, name, got, exp);
            $display("sim failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic abort_run(input string what);
        $display("%0t %s", $time, what);
        $display("sim failed");
        $fatal(1, "%s", what);
    endtask

    // Bus traffic seen at each edge belongs to the cycle that just ended
    always @(posedge clk)
    begin
        logic af;
        af = host_rx.c0_alm_full || host_rx.c1_alm_full;
        if (!arst_n)
        begin
            af_prev = 1'b0;
        end
        else
        begin
            if (done_irq)
            begin
                irq_seen++;
            end
            // Reads still in the pipe may reach the host after the rise
            if (af)
            begin
                if (!af_prev)
                begin
                    af_reads = 0;
                end
                if (host_tx.c0.valid)
                begin
                    af_reads++;
                end
                if (af_reads > MAX_AF_READS)
                begin
                    abort_run("reads kept reaching the host after almost-full rose");
                end
            end
            af_prev = af;
        end
    end

    task automatic reg_write(input logic [2:0] addr, input logic [63:0] data);
        @(posedge clk);
        cfg_wr    <= 1'b1;
        cfg_addr  <= addr;
        cfg_wdata <= data;
        @(posedge clk);
        cfg_wr    <= 1'b0;
    endtask

    // Read data must show up exactly one cycle after the strobe
    task automatic reg_read(input logic [2:0] addr, output logic [63:0] data);
        @(posedge clk);
        cfg_rd   <= 1'b1;
        cfg_addr <= addr;
        @(negedge clk);
        check_value("cfg_rvalid", DATA_W'(cfg_rvalid), DATA_W'(0));
        @(posedge clk);
        cfg_rd   <= 1'b0;
        @(negedge clk);
        check_value("cfg_rvalid", DATA_W'(cfg_rvalid), DATA_W'(1));
        data = cfg_rdata;
    endtask

    task automatic wait_for_irq(input int irq_before);
        int n;
        n = 0;
        while (irq_seen == irq_before && n < DONE_TIMEOUT)
        begin
            @(negedge clk);
            n++;
        end
        if (irq_seen == irq_before)
        begin
            abort_run("timed out waiting for done_irq");
        end
    endtask

    task automatic check_readback();
        logic [63:0] src_val;
        logic [63:0] dst_val;
        logic [63:0] len_val;
        logic [63:0] got;
        src_val = {$random(seed), $random(seed)};
        dst_val = {$random(seed), $random(seed)};
        len_val = {$random(seed), $random(seed)};
        reg_write(REG_SRC, src_val);
        reg_write(REG_DST, dst_val);
        reg_write(REG_LEN, len_val);
        // Registers keep only the address and length widths
        reg_read(REG_SRC, got);
        check_value("cfg_rdata src", DATA_W'(got), DATA_W'(src_val[ADDR_W-1:0]));
        reg_read(REG_DST, got);
        check_value("cfg_rdata dst", DATA_W'(got), DATA_W'(dst_val[ADDR_W-1:0]));
        reg_read(REG_LEN, got);
        check_value("cfg_rdata len", DATA_W'(got), DATA_W'(len_val[15:0]));
        reg_read(3'd6, got);
        check_value("cfg_rdata unmapped", DATA_W'(got), DATA_W'(0));
    endtask

    task automatic run_job(input logic [ADDR_W-1:0] src, input logic [ADDR_W-1:0] dst,
                           input logic [15:0] len);
        int          irq_before;
        int          log_before;
        int          done_cycle;
        int          reads;
        int          writes;
        int          hits;
        int          line_hits [logic [ADDR_W-1:0]];
        logic [63:0] status_word;
        irq_before = irq_seen;
        log_before = i_host_model.log_addr.size();
        reads      = 0;
        writes     = 0;
        reg_write(REG_SRC, 64'(src));
        reg_write(REG_DST, 64'(dst));
        reg_write(REG_LEN, 64'(len));
        reg_write(REG_CTRL, 64'd1);
        wait_for_irq(irq_before);
        done_cycle = i_host_model.cycle;
        // Quiet period catches late requests or a second pulse
        repeat (SETTLE) @(negedge clk);
        check_value("done_irq pulses", DATA_W'(irq_seen - irq_before), DATA_W'(1));
        // Tally the host request log entries that belong to this job
        for (int k = log_before; k < i_host_model.log_addr.size(); k++)
        begin
            // Every request of the job reaches the host before done is seen
            if (i_host_model.log_cycle[k] >= done_cycle)
            begin
                abort_run("host request logged after done_irq");
            end
            if (i_host_model.log_write[k])
            begin
                writes++;
                line_hits[i_host_model.log_addr[k]]++;
            end
            else
            begin
                reads++;
            end
        end
        check_value("host_tx reads", DATA_W'(reads), DATA_W'(len));
        check_value("host_tx writes", DATA_W'(writes), DATA_W'(len));
        for (int i = 0; i < int'(len); i++)
        begin
            hits = line_hits.exists(dst + ADDR_W'(i)) ? line_hits[dst + ADDR_W'(i)] : 0;
            check_value("writes per line", DATA_W'(hits), DATA_W'(1));
            check_value("destination line", i_host_model.line_at(dst + ADDR_W'(i)),
                        i_host_model.line_at(src + ADDR_W'(i)));
        end
        // Idle and done, with both counters at the job length
        reg_read(REG_STATUS, status_word);
        check_value("status", DATA_W'(status_word), DATA_W'({len, 16'h0, len, 14'h0, 2'b10}));
    endtask

    initial
    begin
        logic [ADDR_W-1:0] src;
        logic [ADDR_W-1:0] dst;
        logic [15:0]       len;
        clk       = 1'b0;
        arst_n    = 1'b1;
        cfg_wr    = 1'b0;
        cfg_rd    = 1'b0;
        cfg_addr  = '0;
        cfg_wdata = '0;
        #1;
        arst_n = 1'b0;
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;

        check_readback();

        // Empty job must finish without any host traffic
        run_job(ADDR_W'(32'h1000), ADDR_W'(32'h2000), 16'd0);

        for (int j = 0; j < N_JOBS; j++)
        begin
            len = 16'(1 + {$random(seed)} % MAX_LEN);
            src = ADDR_W'({$random(seed)});
            // Gap keeps source and destination apart
            dst = src + ADDR_W'(MAX_LEN) + ADDR_W'({$random(seed)} % 1024);
            run_job(src, dst, len);
        end

        run_job(ADDR_W'(32'h3000), ADDR_W'(32'h4000), 16'd0);

        $display("sim passed");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+design
design/host_chan_pkg.sv
design/hc_pipe_stages.sv
design/hc_shim.sv
design/hc_copy_engine.sv
design/hc_csr.sv
design/hc_top.sv
dv/hc_host_model.sv
dv/hc_tb.sv
